/* design/armPkg.sv */
package armPkg;

  // One instruction word, three decodings
  typedef union packed {
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        immFlag;   // Rotated immediate as second operand
      logic [3:0]  cmd;
      logic        setFlags;
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] src2;      // rot/imm8 or Rm in [3:0]
    } dpFmt;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        immFlag;
      logic        preIndex;
      logic        up;        // Add offset when set
      logic        byteAcc;
      logic        writeBack;
      logic        load;
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] offset12;
    } memFmt;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        immFlag;
      logic        link;
      logic [23:0] offset24;  // Word offset, signed
    } brFmt;
  } instrWordT;

  // Opcode field
  localparam logic [1:0] opDp  = 2'b00;
  localparam logic [1:0] opMem = 2'b01;
  localparam logic [1:0] opBr  = 2'b10;

  // Data-processing cmd field
  localparam logic [3:0] cmdAnd = 4'b0000;
  localparam logic [3:0] cmdSub = 4'b0010;
  localparam logic [3:0] cmdAdd = 4'b0100;
  localparam logic [3:0] cmdAdc = 4'b0101;
  localparam logic [3:0] cmdOrr = 4'b1100;

  typedef logic [2:0] aluCtrlT;
  localparam aluCtrlT aluAdd = 3'd0;
  localparam aluCtrlT aluAdc = 3'd1;
  localparam aluCtrlT aluSub = 3'd2;
  localparam aluCtrlT aluAnd = 3'd3;
  localparam aluCtrlT aluOrr = 3'd4;

  typedef logic [1:0] immSrcT;
  localparam immSrcT immRot   = 2'd0;
  localparam immSrcT immOff12 = 2'd1;
  localparam immSrcT immBr24  = 2'd2;

  typedef logic [1:0] fwdSelT;
  localparam fwdSelT fwdReg = 2'd0;  // Register file value
  localparam fwdSelT fwdWb  = 2'd1;
  localparam fwdSelT fwdMem = 2'd2;

  typedef logic [3:0] condT;
  localparam condT condEq = 4'h0;
  localparam condT condNe = 4'h1;
  localparam condT condCs = 4'h2;
  localparam condT condCc = 4'h3;
  localparam condT condMi = 4'h4;
  localparam condT condPl = 4'h5;
  localparam condT condVs = 4'h6;
  localparam condT condVc = 4'h7;
  localparam condT condHi = 4'h8;
  localparam condT condLs = 4'h9;
  localparam condT condGe = 4'hA;
  localparam condT condLt = 4'hB;
  localparam condT condGt = 4'hC;
  localparam condT condLe = 4'hD;
  localparam condT condAl = 4'hE;

endpackage

/* design/alu.sv */
`timescale 1ns/1ps
module alu (
  input  logic            [31:0] a,
  input  logic            [31:0] b,
  input  armPkg::aluCtrlT        aluCtrl,
  input  logic                   carryIn,
  output logic            [31:0] result,
  output logic            [3:0]  aluFlags   // NZCV
);
  logic [31:0] bArith;
  logic        cinArith;
  logic [32:0] sum;
  logic        isLogic;
  logic        overflow;

  // Subtract is a + ~b + 1
  always_comb begin
    bArith = (aluCtrl == armPkg::aluSub) ? ~b : b;
    case (aluCtrl)
      armPkg::aluSub: cinArith = 1'b1;
      armPkg::aluAdc: cinArith = carryIn;
      default:        cinArith = 1'b0;
    endcase
  end

  assign sum = {1'b0, a} + {1'b0, bArith} + {32'd0, cinArith};

  always_comb begin
    isLogic = 1'b0;
    case (aluCtrl)
      armPkg::aluAnd: begin
        result  = a & b;
        isLogic = 1'b1;
      end
      armPkg::aluOrr: begin
        result  = a | b;
        isLogic = 1'b1;
      end
      default: result = sum[31:0];
    endcase
  end

  // Same-sign operands giving an opposite-sign sum
  assign overflow = ~(a[31] ^ bArith[31]) & (a[31] ^ sum[31]);

  assign aluFlags = {result[31], (result == 32'd0), ~isLogic & sum[32], ~isLogic & overflow};

endmodule

/* design/immExtend.sv */
`timescale 1ns/1ps
module immExtend (
  input  logic [23:0]    instr,
  input  armPkg::immSrcT immSrc,
  output logic [31:0]    extImm
);
  logic [63:0] rotPair;   // Two copies, so a right shift rotates

  // imm8 rotated right by twice rot4
  assign rotPair = {2{{24'd0, instr[7:0]}}} >> {instr[11:8], 1'b0};

  always_comb begin
    case (immSrc)
      armPkg::immRot:   extImm = rotPair[31:0];
      armPkg::immOff12: extImm = {20'd0, instr[11:0]};
      armPkg::immBr24:  extImm = {{6{instr[23]}}, instr[23:0], 2'b00};  // Words to bytes
      default:          extImm = 32'd0;
    endcase
  end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps
module regFile (
  input  logic        clk,
  input  logic        rstN,
  input  logic        we3,
  input  logic [3:0]  ra1,
  input  logic [3:0]  ra2,
  input  logic [3:0]  wa3,
  input  logic [31:0] wd3,
  input  logic [31:0] r15,   // PC+8
  output logic [31:0] rd1,
  output logic [31:0] rd2
);
  logic [31:0] regs [0:14];  // R0 to R14

  // Falling edge write, decode reads the new value the same cycle
  always_ff @(negedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 15; i++) regs[i] <= '0;
    end else if (we3 && wa3 != 4'hF) begin
      regs[wa3] <= wd3;
    end
  end

  assign rd1 = (ra1 == 4'hF) ? r15 : regs[ra1];
  assign rd2 = (ra2 == 4'hF) ? r15 : regs[ra2];

endmodule

/* design/controlUnit.sv */
`timescale 1ns/1ps
module controlUnit (
  input  logic              clk,
  input  logic              rstN,
  input  armPkg::instrWordT instrD,
  input  logic [3:0]        aluFlagsE,    // NZCV from the ALU
  input  logic              flushE,
  output logic [1:0]        regSrcD,
  output armPkg::immSrcT    immSrcD,
  output logic              aluSrcE,
  output armPkg::aluCtrlT   aluCtrlE,
  output logic              carryE,
  output logic              branchTakenE,
  output logic              memWrite,     // M stage
  output logic              memToRegE,
  output logic              regWriteM,
  output logic              regWriteW,
  output logic              memToRegW,
  output logic              pcSrcW
);
  logic            regWriteD, memWriteD, memToRegD, branchD, flagWriteD, aluSrcD, pcSrcD;
  armPkg::aluCtrlT aluCtrlD;
  logic            regWriteE, memWriteE, memToRegRawE, branchE, flagWriteE, pcSrcE;
  armPkg::condT    condE;
  logic            condPassE;
  logic [3:0]      flags;
  logic            flagN, flagZ, flagC, flagV;
  logic            memToRegM, pcSrcM;

  // Main decoder
  always_comb begin
    regSrcD    = 2'b00;
    immSrcD    = armPkg::immRot;
    aluSrcD    = 1'b0;
    aluCtrlD   = armPkg::aluAdd;
    regWriteD  = 1'b0;
    memWriteD  = 1'b0;
    memToRegD  = 1'b0;
    branchD    = 1'b0;
    flagWriteD = 1'b0;
    pcSrcD     = 1'b0;
    case (instrD.dpFmt.op)
      armPkg::opDp: begin
        aluSrcD    = instrD.dpFmt.immFlag;
        regWriteD  = 1'b1;
        flagWriteD = instrD.dpFmt.setFlags;
        case (instrD.dpFmt.cmd)
          armPkg::cmdAdd: aluCtrlD = armPkg::aluAdd;
          armPkg::cmdAdc: aluCtrlD = armPkg::aluAdc;
          armPkg::cmdSub: aluCtrlD = armPkg::aluSub;
          armPkg::cmdAnd: aluCtrlD = armPkg::aluAnd;
          armPkg::cmdOrr: aluCtrlD = armPkg::aluOrr;
          default: begin                          // Unsupported cmd runs as a no-op
            regWriteD  = 1'b0;
            flagWriteD = 1'b0;
          end
        endcase
      end
      armPkg::opMem: begin
        regSrcD   = instrD.memFmt.load ? 2'b00 : 2'b10;  // STR reads Rd on port 2
        immSrcD   = armPkg::immOff12;
        aluSrcD   = 1'b1;
        aluCtrlD  = instrD.memFmt.up ? armPkg::aluAdd : armPkg::aluSub;
        regWriteD = instrD.memFmt.load;
        memWriteD = ~instrD.memFmt.load;
        memToRegD = instrD.memFmt.load;
        pcSrcD    = instrD.memFmt.load & (instrD.memFmt.rd == 4'hF);  // LDR PC
      end
      armPkg::opBr: begin
        regSrcD = 2'b01;                          // Base is R15
        immSrcD = armPkg::immBr24;
        aluSrcD = 1'b1;
        branchD = ~instrD.brFmt.link;             // No BL, link turns it off
      end
      default: ;
    endcase
  end

  // D to E register, flush inserts a bubble
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      regWriteE    <= 1'b0;
      memWriteE    <= 1'b0;
      memToRegRawE <= 1'b0;
      branchE      <= 1'b0;
      flagWriteE   <= 1'b0;
      pcSrcE       <= 1'b0;
      aluSrcE      <= 1'b0;
      aluCtrlE     <= armPkg::aluAdd;
      condE        <= armPkg::condAl;
    end else begin
      regWriteE    <= regWriteD;
      memWriteE    <= memWriteD;
      memToRegRawE <= memToRegD;
      branchE      <= branchD;
      flagWriteE   <= flagWriteD;
      pcSrcE       <= pcSrcD;
      aluSrcE      <= aluSrcD;
      aluCtrlE     <= aluCtrlD;
      condE        <= instrD.dpFmt.cond;
    end
  end

  assign {flagN, flagZ, flagC, flagV} = flags;

  // Condition check against the committed flags
  always_comb begin
    case (condE)
      armPkg::condEq: condPassE = flagZ;
      armPkg::condNe: condPassE = ~flagZ;
      armPkg::condCs: condPassE = flagC;
      armPkg::condCc: condPassE = ~flagC;
      armPkg::condMi: condPassE = flagN;
      armPkg::condPl: condPassE = ~flagN;
      armPkg::condVs: condPassE = flagV;
      armPkg::condVc: condPassE = ~flagV;
      armPkg::condHi: condPassE = flagC & ~flagZ;
      armPkg::condLs: condPassE = ~flagC | flagZ;
      armPkg::condGe: condPassE = (flagN == flagV);
      armPkg::condLt: condPassE = (flagN != flagV);
      armPkg::condGt: condPassE = ~flagZ & (flagN == flagV);
      armPkg::condLe: condPassE = flagZ | (flagN != flagV);
      armPkg::condAl: condPassE = 1'b1;
      default:        condPassE = 1'b0;       // NV never executes
    endcase
  end

  // NZCV, written at the end of E
  always_ff @(posedge clk) begin
    if (!rstN) flags <= 4'b0000;
    else if (flagWriteE && condPassE) flags <= aluFlagsE;
  end

  assign carryE       = flagC;                  // ADC carry in
  assign branchTakenE = branchE & condPassE;
  assign memToRegE    = memToRegRawE & condPassE;  // Load in E, for the stall

  // E to M and M to W, only surviving bits move on
  always_ff @(posedge clk) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memWrite  <= 1'b0;
      memToRegM <= 1'b0;
      pcSrcM    <= 1'b0;
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
      pcSrcW    <= 1'b0;
    end else begin
      regWriteM <= regWriteE & condPassE;
      memWrite  <= memWriteE & condPassE;
      memToRegM <= memToRegE;
      pcSrcM    <= pcSrcE & condPassE;
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
      pcSrcW    <= pcSrcM;
    end
  end

endmodule

/* design/hazardUnit.sv */
`timescale 1ns/1ps
module hazardUnit (
  input  logic           match1EM,
  input  logic           match1EW,
  input  logic           match2EM,
  input  logic           match2EW,
  input  logic           match12DE,
  input  logic           regWriteM,
  input  logic           regWriteW,
  input  logic           memToRegE,
  input  logic           branchTakenE,
  output armPkg::fwdSelT forwardAE,
  output armPkg::fwdSelT forwardBE,
  output logic           stallF,
  output logic           stallD,
  output logic           flushD,
  output logic           flushE
);
  logic ldrStall;

  // M result is younger, so it wins over W
  always_comb begin
    if (match1EM && regWriteM) forwardAE = armPkg::fwdMem;
    else if (match1EW && regWriteW) forwardAE = armPkg::fwdWb;
    else forwardAE = armPkg::fwdReg;

    if (match2EM && regWriteM) forwardBE = armPkg::fwdMem;
    else if (match2EW && regWriteW) forwardBE = armPkg::fwdWb;
    else forwardBE = armPkg::fwdReg;
  end

  // Load data exists only after M, so hold D one cycle
  assign ldrStall = match12DE & memToRegE;

  assign stallF = ldrStall;
  assign stallD = ldrStall;
  assign flushD = branchTakenE;               // Drop the instruction in D
  assign flushE = ldrStall | branchTakenE;    // Bubble into E

endmodule

/* design/pipeDatapath.sv */
`timescale 1ns/1ps
module pipeDatapath #(
  parameter logic [31:0] resetPc = 32'h0000_0000
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic [1:0]        regSrcD,
  input  armPkg::immSrcT    immSrcD,
  input  logic              aluSrcE,
  input  armPkg::aluCtrlT   aluCtrlE,
  input  logic              carryE,
  input  logic              branchTakenE,
  input  logic              memToRegW,
  input  logic              regWriteW,
  input  logic              pcSrcW,
  input  armPkg::fwdSelT    forwardAE,
  input  armPkg::fwdSelT    forwardBE,
  input  logic              stallF,
  input  logic              stallD,
  input  logic              flushD,
  input  logic              flushE,
  output logic [31:0]       pcF,
  input  logic [31:0]       instrF,
  output armPkg::instrWordT instrD,
  output logic [31:0]       aluOutM,
  output logic [31:0]       writeDataM,
  input  logic [31:0]       readDataM,
  output logic [3:0]        aluFlagsE,
  output logic              match1EM,
  output logic              match1EW,
  output logic              match2EM,
  output logic              match2EW,
  output logic              match12DE
);
  logic [31:0] pcPlus4F, pcNextF;
  logic [3:0]  ra1D, ra2D, wa3D;
  logic [31:0] rd1D, rd2D, extImmD;
  logic [3:0]  ra1E, ra2E, wa3E;
  logic [31:0] rd1E, rd2E, extImmE;
  logic [31:0] srcAE, srcBE, writeDataE, aluResultE;
  logic [3:0]  wa3M, wa3W;
  logic [31:0] aluOutW, readDataW, resultW;

  // Three-way bypass, shared by both operands
  function automatic logic [31:0] bypass(input armPkg::fwdSelT sel,
                                         input logic [31:0] regVal,
                                         input logic [31:0] wbVal,
                                         input logic [31:0] memVal);
    case (sel)
      armPkg::fwdMem: return memVal;
      armPkg::fwdWb:  return wbVal;
      default:        return regVal;
    endcase
  endfunction

  // Fetch
  assign pcPlus4F = pcF + 32'd4;

  always_comb begin
    if (branchTakenE) pcNextF = aluResultE;   // Branch target from E
    else if (pcSrcW) pcNextF = resultW;       // Loaded PC
    else pcNextF = pcPlus4F;
  end

  always_ff @(posedge clk) begin
    if (!rstN) pcF <= resetPc;
    else if (!stallF) pcF <= pcNextF;
  end

  // F to D, held on stall and cleared on flush
  always_ff @(posedge clk) begin
    if (!rstN || flushD) instrD <= '0;
    else if (!stallD) instrD <= instrF;
  end

  // Decode
  assign ra1D = regSrcD[0] ? 4'hF : instrD.dpFmt.rn;
  assign ra2D = regSrcD[1] ? instrD.memFmt.rd : instrD.dpFmt.src2[3:0];
  assign wa3D = instrD.dpFmt.rd;

  regFile rf (
    .clk (clk),
    .rstN(rstN),
    .we3 (regWriteW),
    .ra1 (ra1D),
    .ra2 (ra2D),
    .wa3 (wa3W),
    .wd3 (resultW),
    .r15 (pcPlus4F),                          // PC+8 of the instruction in D
    .rd1 (rd1D),
    .rd2 (rd2D)
  );

  immExtend ext (
    .instr (instrD[23:0]),
    .immSrc(immSrcD),
    .extImm(extImmD)
  );

  // D to E, a flush leaves an all-zero bubble
  always_ff @(posedge clk) begin
    if (flushE) begin
      rd1E    <= '0;
      rd2E    <= '0;
      extImmE <= '0;
      ra1E    <= '0;
      ra2E    <= '0;
      wa3E    <= '0;
    end else begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      extImmE <= extImmD;
      ra1E    <= ra1D;
      ra2E    <= ra2D;
      wa3E    <= wa3D;
    end
  end

  // Execute
  assign srcAE      = bypass(forwardAE, rd1E, resultW, aluOutM);
  assign writeDataE = bypass(forwardBE, rd2E, resultW, aluOutM);  // Store data too
  assign srcBE      = aluSrcE ? extImmE : writeDataE;

  alu alu0 (
    .a       (srcAE),
    .b       (srcBE),
    .aluCtrl (aluCtrlE),
    .carryIn (carryE),
    .result  (aluResultE),
    .aluFlags(aluFlagsE)
  );

  // E to M, then M to W
  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
    wa3M       <= wa3E;
    aluOutW    <= aluOutM;
    readDataW  <= readDataM;
    wa3W       <= wa3M;
  end

  // Writeback
  assign resultW = memToRegW ? readDataW : aluOutW;

  // Register matches for the hazard unit
  assign match1EM  = (wa3M == ra1E);
  assign match1EW  = (wa3W == ra1E);
  assign match2EM  = (wa3M == ra2E);
  assign match2EW  = (wa3W == ra2E);
  assign match12DE = (wa3E == ra1D) | (wa3E == ra2D);  // Either D source hits E dest

endmodule

/* design/armCore.sv */
`timescale 1ns/1ps
module armCore #(
  parameter logic [31:0] resetPc = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rstN,
  output logic [31:0] pcF,
  input  logic [31:0] instrF,
  output logic        memWrite,
  output logic [31:0] aluOutM,     // Data address
  output logic [31:0] writeDataM,
  input  logic [31:0] readDataM
);
  // Control to datapath
  logic [1:0]        regSrcD;
  armPkg::immSrcT    immSrcD;
  logic              aluSrcE, carryE, branchTakenE;
  armPkg::aluCtrlT   aluCtrlE;
  logic              memToRegE, regWriteM, regWriteW, memToRegW, pcSrcW;
  // Datapath back to control
  armPkg::instrWordT instrD;
  logic [3:0]        aluFlagsE;
  // Hazard handling
  logic              match1EM, match1EW, match2EM, match2EW, match12DE;
  armPkg::fwdSelT    forwardAE, forwardBE;
  logic              stallF, stallD, flushD, flushE;

  controlUnit ctrl (
    .clk, .rstN,
    .instrD, .aluFlagsE, .flushE,
    .regSrcD, .immSrcD,
    .aluSrcE, .aluCtrlE, .carryE, .branchTakenE,
    .memWrite, .memToRegE,
    .regWriteM, .regWriteW, .memToRegW, .pcSrcW
  );

  pipeDatapath #(
    .resetPc(resetPc)
  ) dp (
    .clk, .rstN,
    .regSrcD, .immSrcD,
    .aluSrcE, .aluCtrlE, .carryE, .branchTakenE,
    .memToRegW, .regWriteW, .pcSrcW,
    .forwardAE, .forwardBE,
    .stallF, .stallD, .flushD, .flushE,
    .pcF, .instrF, .instrD,
    .aluOutM, .writeDataM, .readDataM,
    .aluFlagsE,
    .match1EM, .match1EW, .match2EM, .match2EW, .match12DE
  );

  hazardUnit hzd (
    .match1EM, .match1EW, .match2EM, .match2EW, .match12DE,
    .regWriteM, .regWriteW, .memToRegE, .branchTakenE,
    .forwardAE, .forwardBE,
    .stallF, .stallD, .flushD, .flushE
  );

endmodule

/* tb/armCoreTb.sv */
`timescale 1ns/1ps
module armCoreTb;
  localparam int          rawSize = 1024;
  localparam logic [31:0] resetPc = 32'h0000_0000;

  logic        clk;
  logic        rstN;
  logic [31:0] pcF, instrF;
  logic        memWrite;
  logic [31:0] aluOutM, writeDataM, readDataM;

  logic [31:0] raw [0:rawSize-1];   // Tagged test data records
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  logic [31:0] expAddr [$];         // Expected stores in order
  logic [31:0] expData [$];
  int          storeIdx, errors, testErrors;
  int          testsRun, testsFailed;
  int          cycles, totalLimit;
  logic        running;             // Store monitor enable

  armCore #(.resetPc(resetPc)) UUT (
    .clk, .rstN, .pcF, .instrF,
    .memWrite, .aluOutM, .writeDataM, .readDataM
  );

  // Both memories answer in the same cycle
  assign instrF    = imem[pcF[9:2]];
  assign readDataM = dmem[aluOutM[9:2]];

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Background pattern from the whole word index
  function automatic logic [31:0] fillWord(input int idx);
    return (idx * 32'h9E37_79B9) ^ 32'h5A5A_0000;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("[ERROR] %0t ns %s got %08h expected %08h", $time, name, got, want);
      errors++;
      testErrors++;
    end
  endtask

  // Store monitor on the falling edge
  always @(negedge clk) begin
    if (running && memWrite === 1'b1) begin
      if (storeIdx < expAddr.size()) begin
        checkValue("aluOutM", aluOutM, expAddr[storeIdx]);
        checkValue("writeDataM", writeDataM, expData[storeIdx]);
      end else begin
        $display("Unexpected extra store of %08h to %08h at %0t ns", writeDataM, aluOutM, $time);
        errors++;
        testErrors++;
      end
      storeIdx++;
      dmem[aluOutM[9:2]] = writeDataM;
    end
  end

  // Global guard over the whole run
  always @(posedge clk) begin
    cycles++;
    if (totalLimit > 0 && cycles > totalLimit) begin
      $display("Run stopped, global limit of %0d cycles reached", totalLimit);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    int   p, plen, limit, waited, tnum, n;
    logic badData;
    rstN = 1'b0;
    running = 1'b0;
    errors = 0;
    testsRun = 0;
    testsFailed = 0;
    cycles = 0;
    totalLimit = 0;
    badData = 1'b0;
    for (int i = 0; i < rawSize; i++) raw[i] = 32'd0;  // Zero tag ends the data
    $readmemh("tb/testdata.mem", raw);

    // First pass sums the per-test limits
    p = 0;
    plen = 0;
    while (raw[p] != 32'd0 && !badData) begin
      case (raw[p])
        32'd1: begin
          plen = 0;
          p += 2;
        end
        32'd2: begin
          plen += raw[p+1];
          p += raw[p+1] + 2;
        end
        32'd3, 32'd4: p += 3;
        32'd5: begin
          totalLimit += plen * 8 + 20 + 16 + 12;   // Reset and drain on top
          p += 1;
        end
        default: badData = 1'b1;
      endcase
    end
    if (badData) $display("Test data holds an unknown record tag at word %0d", p);

    p = 0;
    while (raw[p] == 32'd1 && !badData) begin
      tnum = raw[p+1];
      p += 2;
      plen = 0;
      @(posedge clk);
      #1 rstN = 1'b0;
      running = 1'b0;
      for (int i = 0; i < 256; i++) begin
        imem[i] = 32'd0;
        dmem[i] = fillWord(i);
      end
      expAddr.delete();
      expData.delete();
      while (raw[p] != 32'd5 && raw[p] != 32'd0) begin
        if (raw[p] == 32'd2) begin
          n = raw[p+1];
          for (int k = 0; k < n; k++) imem[plen+k] = raw[p+2+k];
          plen += n;
          p += n + 2;
        end else if (raw[p] == 32'd3) begin
          dmem[raw[p+1][9:2]] = raw[p+2];
          p += 3;
        end else begin
          expAddr.push_back(raw[p+1]);
          expData.push_back(raw[p+2]);
          p += 3;
        end
      end
      p++;
      storeIdx = 0;
      testErrors = 0;
      repeat (16) @(posedge clk);
      #1;
      checkValue("pcF", pcF, resetPc);  // PC parked at the reset address
      rstN = 1'b1;
      running = 1'b1;
      limit = plen * 8 + 20;
      waited = 0;
      while (storeIdx < expAddr.size() && waited < limit) begin
        @(posedge clk);
        waited++;
      end
      // Stray stores behind the last expected one
      repeat (8) @(posedge clk);
      if (storeIdx < expAddr.size()) begin
        $display("Test %0d saw only %0d of %0d expected stores within %0d cycles",
                 tnum, storeIdx, expAddr.size(), limit);
        errors++;
        testErrors++;
      end
      testsRun++;
      if (testErrors != 0) testsFailed++;
      $display("Test %0d %s, %0d stores, %0d errors", tnum,
               (testErrors == 0) ? "passed" : "failed", storeIdx, testErrors);
    end
    running = 1'b0;

    $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0 && testsRun > 0 && !badData) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* tb/testdata.mem */
// Tags: 1 test id | 2 count words... | 3 addr data (initial) | 4 addr data (expected store) | 5 end
// All fields hex, program words load from address 0 up
1 01
2 05 E2801005 E2812003 E0423001 E2034006 E1845002
2 05 E28564FF E2807C01 E5875000 E5876004 E5873008
4 00000100 0000000A
4 00000104 FF00000A
4 00000108 00000003
5
// Load followed by use
1 02
3 00000200 00001234
3 00000204 00000100
2 07 E2801C02 E5912000 E0823002 E5914004 E5843000 E0835004 E5815008
4 00000100 00002468
4 00000208 00002568
5
// Taken B, untaken BNE, taken BEQ
1 03
2 06 E2801C01 E2802007 EA000001 E5812000 E5812004 E2523007
2 05 1A000000 E5812008 0A000000 E581200C E5813010
4 00000108 00000007
4 00000110 00000000
5
// SUBS then conditional adds and ADC
1 04
2 07 E2801C01 E2802005 E2523005 02834001 12845010 E2A46000 E2527006
2 06 E2A48000 E5814000 E5815004 E5816008 E581700C E5818010
4 00000100 00000001
4 00000104 00000000
4 00000108 00000002
4 0000010C FFFFFFFF
4 00000110 00000001
5
// STR of R15 and offset stores
1 05
2 05 E2801C03 E581F000 E2802055 E5812024 E581F010
4 00000300 0000000C
4 00000324 00000055
4 00000310 00000018
5

/* tb.f */
design/armPkg.sv
design/alu.sv
design/immExtend.sv
design/regFile.sv
design/controlUnit.sv
design/hazardUnit.sv
design/pipeDatapath.sv
design/armCore.sv
tb/armCoreTb.sv

/* Makefile */
# Verilator build and run of the ARM pipeline testbench
VERILATOR ?= verilator
TOP       ?= armCoreTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "\*\* PASS \*\*" $(LOG) && echo "Simulation passed" || \
	  (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
